// File: pmp_access_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_access_arbiter (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          req_valid_i,
  input  wire  pmp_pkg::pmp_access_e   req_type_i,
  input  wire  pmp_pkg::priv_e         req_priv_i,
  input  wire  [`PMP_REGIONS-1:0]      match_i,
  input  wire  [`PMP_REGIONS-1:0]      allow_i,
  input  wire  [`PMP_REGIONS-1:0]      lock_i,
  output logic                         resp_valid_o,
  output logic                         resp_fault_o,
  output logic [`PMP_CAUSE_W-1:0]      resp_cause_o
);

  logic                    hit;
  logic                    hit_allow;
  logic                    hit_lock;
  logic                    fault;
  logic [`PMP_CAUSE_W-1:0] cause;

  // Scan from the top so the lowest matching entry wins
  always_comb begin
    hit       = 1'b0;
    hit_allow = 1'b0;
    hit_lock  = 1'b0;
    for (int i = `PMP_REGIONS - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        hit       = 1'b1;
        hit_allow = allow_i[i];
        hit_lock  = lock_i[i];
      end
    end
  end

  // M-mode is only held back by locked entries
  assign fault = (req_priv_i == pmp_pkg::PRIV_M) ? (hit && hit_lock && !hit_allow)
                                                 : (!hit || !hit_allow);

  always_comb begin
    case (req_type_i)
      pmp_pkg::PMP_ACC_EXEC:  cause = `PMP_CAUSE_W'(`PMP_CAUSE_INSTR);
      pmp_pkg::PMP_ACC_WRITE: cause = `PMP_CAUSE_W'(`PMP_CAUSE_STORE);
      default:                cause = `PMP_CAUSE_W'(`PMP_CAUSE_LOAD);
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_o <= 1'b0;
      resp_fault_o <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
      resp_fault_o <= req_valid_i && fault;
    end
  end

  // Cause is zero for a granted access
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      resp_cause_o <= fault ? cause : '0;
    end
  end

endmodule

`default_nettype wire

// File: pmp_cfg.svh
`ifndef PMP_CFG_SVH
`define PMP_CFG_SVH

// Number of PMP entries, a multiple of four
`define PMP_REGIONS 8

// First pmpcfg and first pmpaddr CSR
`define PMP_CSR_CFG_BASE 12'h3A0
`define PMP_CSR_ADDR_BASE 12'h3B0

// Exception causes
`define PMP_CAUSE_INSTR 1
`define PMP_CAUSE_ILLEGAL 2
`define PMP_CAUSE_LOAD 5
`define PMP_CAUSE_STORE 7

`define PMP_CAUSE_W 6

`endif

// File: pmp_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_checker (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        csr_we_i,
  input  wire  [11:0]                csr_addr_i,
  input  wire  [31:0]                csr_wdata_i,
  input  wire  pmp_pkg::priv_e       csr_priv_i,
  input  wire  [31:0]                csr_rdata_i,
  input  wire                        csr_illegal_i,
  input  wire                        req_valid_i,
  input  wire  [31:0]                req_addr_i,
  input  wire  pmp_pkg::pmp_access_e req_type_i,
  input  wire  pmp_pkg::priv_e       req_priv_i,
  input  wire                        resp_valid_i,
  input  wire                        resp_fault_i,
  input  wire  [`PMP_CAUSE_W-1:0]    resp_cause_i,
  input  wire  [7:0]                 test_id_i,
  input  wire                        test_end_i,
  input  wire                        run_end_i,
  output int                         error_count_o
);

  localparam int CFG_WORDS = `PMP_REGIONS / 4;

  // Reference copy of the PMP CSRs
  pmp_pkg::pmpncfg_t       cfg_m [`PMP_REGIONS];
  logic [31:0]             addr_m [`PMP_REGIONS];
  logic                    exp_valid;
  logic                    exp_fault;
  logic                    exp_illegal;
  logic [`PMP_CAUSE_W-1:0] exp_cause;
  int errors = 0;
  int total_checks = 0;
  int test_checks = 0;
  int test_errors = 0;
  int tests_done = 0;

  assign error_count_o = errors;

  function automatic string test_name(input logic [7:0] id);
    case (id)
      8'd1: return "reset state";
      8'd2: return "WARL writes";
      8'd3: return "locking";
      8'd4: return "U-mode CSR access";
      8'd5: return "random access checks";
      default: return "unnamed";
    endcase
  endfunction

  function automatic logic implemented(input logic [11:0] a);
    int ci;
    int ai;
    ci = int'(a) - int'(`PMP_CSR_CFG_BASE);
    ai = int'(a) - int'(`PMP_CSR_ADDR_BASE);
    return (ci >= 0 && ci < CFG_WORDS) || (ai >= 0 && ai < `PMP_REGIONS);
  endfunction

  function automatic logic [31:0] read_csr(input logic [11:0] a);
    pmp_pkg::pmpcfg_word_u word;
    int ci;
    int ai;
    ci = int'(a) - int'(`PMP_CSR_CFG_BASE);
    ai = int'(a) - int'(`PMP_CSR_ADDR_BASE);
    if (ci >= 0 && ci < CFG_WORDS) begin
      for (int j = 0; j < 4; j++) begin
        word.field[j] = cfg_m[4 * ci + j];
      end
      return word.raw;
    end
    if (ai >= 0 && ai < `PMP_REGIONS) begin
      return addr_m[ai];
    end
    return 32'd0;
  endfunction

  // Entry i+1 locked in TOR mode uses addr i as its base
  function automatic logic tor_lock_above(input int i);
    if (i + 1 >= `PMP_REGIONS) begin
      return 1'b0;
    end
    return cfg_m[i + 1].lock && (cfg_m[i + 1].mode == pmp_pkg::PMP_MODE_TOR);
  endfunction

  task automatic apply_write(input logic [11:0] a, input logic [31:0] d);
    pmp_pkg::pmpcfg_word_u word;
    pmp_pkg::pmpncfg_t     nb;
    int ci;
    int ai;
    int r;
    ci = int'(a) - int'(`PMP_CSR_CFG_BASE);
    ai = int'(a) - int'(`PMP_CSR_ADDR_BASE);
    word.raw = d;
    if (ci >= 0 && ci < CFG_WORDS) begin
      for (int j = 0; j < 4; j++) begin
        r = 4 * ci + j;
        nb = word.field[j];
        if (!nb.read && nb.write) begin
          nb.read  = cfg_m[r].read;
          nb.write = cfg_m[r].write;
          nb.exec  = cfg_m[r].exec;
        end
        nb.zero0 = 2'b00;
        if (!cfg_m[r].lock) begin
          cfg_m[r] = nb;
        end
      end
    end
    if (ai >= 0 && ai < `PMP_REGIONS) begin
      if (!cfg_m[ai].lock && !tor_lock_above(ai)) begin
        addr_m[ai] = d;
      end
    end
  endtask

  // Region of 2^(k+3) bytes, k being the count of trailing ones
  function automatic logic napot_hit(input logic [31:0] pa, input logic [31:0] word);
    int k;
    k = 0;
    while (k < 32 && pa[k]) begin
      k++;
    end
    if (k >= 31) begin
      return 1'b1;
    end
    return (word >> (k + 1)) == (pa >> (k + 1));
  endfunction

  function automatic logic expect_fault(input logic [31:0] a, input pmp_pkg::pmp_access_e t,
                                        input pmp_pkg::priv_e p);
    logic [31:0]       word;
    logic [31:0]       base;
    logic              hit;
    logic              ok;
    pmp_pkg::pmpncfg_t c;
    word = {2'b00, a[31:2]};
    hit = 1'b0;
    c = '0;
    for (int i = 0; i < `PMP_REGIONS && !hit; i++) begin
      base = (i == 0) ? 32'd0 : addr_m[i - 1];
      case (cfg_m[i].mode)
        pmp_pkg::PMP_MODE_TOR:   hit = (word >= base) && (word < addr_m[i]);
        pmp_pkg::PMP_MODE_NA4:   hit = (word == addr_m[i]);
        pmp_pkg::PMP_MODE_NAPOT: hit = napot_hit(addr_m[i], word);
        default:                 hit = 1'b0;
      endcase
      if (hit) begin
        c = cfg_m[i];
      end
    end
    if (t == pmp_pkg::PMP_ACC_READ) begin
      ok = c.read;
    end else if (t == pmp_pkg::PMP_ACC_WRITE) begin
      ok = c.write;
    end else begin
      ok = c.exec;
    end
    if (p == pmp_pkg::PRIV_M) begin
      return hit && c.lock && !ok;
    end
    return !hit || !ok;
  endfunction

  function automatic logic [`PMP_CAUSE_W-1:0] cause_for(input pmp_pkg::pmp_access_e t);
    if (t == pmp_pkg::PMP_ACC_EXEC) begin
      return `PMP_CAUSE_W'(`PMP_CAUSE_INSTR);
    end
    if (t == pmp_pkg::PMP_ACC_WRITE) begin
      return `PMP_CAUSE_W'(`PMP_CAUSE_STORE);
    end
    return `PMP_CAUSE_W'(`PMP_CAUSE_LOAD);
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    total_checks++;
    test_checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Outputs settle after the rising edge, inputs change 1 ns after it
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PMP_REGIONS; i++) begin
        cfg_m[i]  = '0;
        addr_m[i] = '0;
      end
      exp_valid   = 1'b0;
      exp_fault   = 1'b0;
      exp_illegal = 1'b0;
      exp_cause   = '0;
    end else begin
      compare("csr_rdata_o", csr_rdata_i, read_csr(csr_addr_i));
      compare("csr_illegal_o", 32'(csr_illegal_i), 32'(exp_illegal));
      compare("resp_valid_o", 32'(resp_valid_i), 32'(exp_valid));
      compare("resp_fault_o", 32'(resp_fault_i), 32'(exp_fault));
      if (exp_valid) begin
        compare("resp_cause_o", 32'(resp_cause_i), 32'(exp_cause));
      end
      // Requests see the registers before a write in the same cycle
      exp_valid   = req_valid_i;
      exp_fault   = req_valid_i && expect_fault(req_addr_i, req_type_i, req_priv_i);
      exp_cause   = exp_fault ? cause_for(req_type_i) : '0;
      exp_illegal = csr_we_i && (csr_priv_i != pmp_pkg::PRIV_M) && implemented(csr_addr_i);
      if (csr_we_i && (csr_priv_i == pmp_pkg::PRIV_M)) begin
        apply_write(csr_addr_i, csr_wdata_i);
      end
    end
    if (test_end_i) begin
      $display("Test %0d (%s): %0d checks, %0d errors", test_id_i, test_name(test_id_i),
               test_checks, test_errors);
      tests_done++;
      test_checks = 0;
      test_errors = 0;
    end
    if (run_end_i) begin
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, total_checks, errors);
    end
  end

endmodule

`default_nettype wire

// File: pmp_csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_csr_decode (
  input  wire                                      clk_i,
  input  wire                                      rst_ni,
  input  wire                                      csr_we_i,
  input  wire  [11:0]                              csr_addr_i,
  input  wire  [31:0]                              csr_wdata_i,
  input  wire  pmp_pkg::priv_e                     csr_priv_i,
  input  wire  pmp_pkg::pmpncfg_t [`PMP_REGIONS-1:0] region_cfg_i,
  input  wire  [`PMP_REGIONS-1:0][31:0]            region_addr_i,
  output logic [`PMP_REGIONS-1:0]                  cfg_we_o,
  output pmp_pkg::pmpncfg_t [`PMP_REGIONS-1:0]     cfg_wdata_o,
  output logic [`PMP_REGIONS-1:0]                  addr_we_o,
  output logic [31:0]                              addr_wdata_o,
  output logic [31:0]                              csr_rdata_o,
  output logic                                     csr_illegal_o
);

  localparam int CFG_WORDS = `PMP_REGIONS / 4;

  pmp_pkg::pmpcfg_word_u                 wr_word;
  pmp_pkg::pmpcfg_word_u [CFG_WORDS-1:0] rd_words;
  logic [CFG_WORDS-1:0]    cfg_sel;
  logic [`PMP_REGIONS-1:0] addr_sel;
  logic                    in_range;
  logic                    we_m;
  logic                    illegal_q;

  // Address decode, one select per implemented CSR
  for (genvar w = 0; w < CFG_WORDS; w++) begin : gen_cfg_sel
    assign cfg_sel[w] = (csr_addr_i == `PMP_CSR_CFG_BASE + w);
  end

  for (genvar r = 0; r < `PMP_REGIONS; r++) begin : gen_addr_sel
    assign addr_sel[r] = (csr_addr_i == `PMP_CSR_ADDR_BASE + r);
  end

  assign in_range = (|cfg_sel) | (|addr_sel);
  assign we_m     = csr_we_i && (csr_priv_i == pmp_pkg::PRIV_M);

  // Each entry takes its own byte of the written pmpcfg word
  assign wr_word.raw  = csr_wdata_i;
  assign addr_wdata_o = csr_wdata_i;

  for (genvar i = 0; i < `PMP_REGIONS; i++) begin : gen_strobe
    assign cfg_we_o[i]    = we_m && cfg_sel[i / 4];
    assign cfg_wdata_o[i] = wr_word.field[i % 4];
    assign addr_we_o[i]   = we_m && addr_sel[i];
  end

  // Read-back of the current registers
  always_comb begin
    for (int w = 0; w < CFG_WORDS; w++) begin
      for (int j = 0; j < 4; j++) begin
        rd_words[w].field[j] = region_cfg_i[4 * w + j];
      end
    end
    csr_rdata_o = '0;
    for (int w = 0; w < CFG_WORDS; w++) begin
      if (cfg_sel[w]) csr_rdata_o = rd_words[w].raw;
    end
    for (int r = 0; r < `PMP_REGIONS; r++) begin
      if (addr_sel[r]) csr_rdata_o = region_addr_i[r];
    end
  end

  // U-mode write to a PMP CSR, flagged on the next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
    end else begin
      illegal_q <= csr_we_i && (csr_priv_i != pmp_pkg::PRIV_M) && in_range;
    end
  end

  assign csr_illegal_o = illegal_q;

endmodule

`default_nettype wire

// File: pmp_pkg.sv
`default_nettype none

package pmp_pkg;

  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // One byte of a pmpcfg CSR
  typedef struct packed {
    logic       lock;
    logic [1:0] zero0;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmpncfg_t;

  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_EXEC  = 2'b10
  } pmp_access_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_e;

  // A pmpcfg word, seen whole or as four entry configs
  typedef union packed {
    logic [31:0]         raw;
    pmpncfg_t [3:0]      field;
  } pmpcfg_word_u;

endpackage

`default_nettype wire

// File: pmp_region.sv
`timescale 1ns/1ps
`default_nettype none

module pmp_region (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       cfg_we_i,
  input  wire  pmp_pkg::pmpncfg_t   cfg_wdata_i,
  input  wire                       addr_we_i,
  input  wire  [31:0]               addr_wdata_i,
  input  wire  pmp_pkg::pmpncfg_t   above_cfg_i,
  input  wire  [31:0]               prev_addr_i,
  input  wire  [31:0]               req_addr_i,
  input  wire  pmp_pkg::pmp_access_e req_type_i,
  output pmp_pkg::pmpncfg_t         cfg_o,
  output logic [31:0]               addr_o,
  output logic                      match_o,
  output logic                      allow_o
);

  pmp_pkg::pmpncfg_t cfg_q;
  pmp_pkg::pmpncfg_t cfg_next;
  logic [31:0]       addr_q;
  logic [31:0]       req_word;
  logic [31:0]       napot_care;
  logic              cfg_upd;
  logic              addr_upd;
  logic              tor_locked_above;

  // WARL view of an incoming config byte
  always_comb begin
    cfg_next = cfg_wdata_i;
    // R=0 with W=1 is reserved, so the old permissions stay
    if (!cfg_wdata_i.read && cfg_wdata_i.write) begin
      cfg_next.read  = cfg_q.read;
      cfg_next.write = cfg_q.write;
      cfg_next.exec  = cfg_q.exec;
    end
    cfg_next.zero0 = 2'b00;
  end

  // A locked TOR entry above uses our addr as its base
  assign tor_locked_above = above_cfg_i.lock &&
                            (above_cfg_i.mode == pmp_pkg::PMP_MODE_TOR);

  assign cfg_upd  = cfg_we_i && !cfg_q.lock;
  assign addr_upd = addr_we_i && !cfg_q.lock && !tor_locked_above;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      if (cfg_upd) begin
        cfg_q <= cfg_next;
      end
      if (addr_upd) begin
        addr_q <= addr_wdata_i;
      end
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

  // Word address of the request, same scale as pmpaddr
  assign req_word = {2'b00, req_addr_i[31:2]};

  // Trailing ones of addr mark the don't-care bits
  assign napot_care = ~(addr_q ^ (addr_q + 32'd1));

  always_comb begin
    case (cfg_q.mode)
      pmp_pkg::PMP_MODE_TOR: begin
        match_o = (req_word >= prev_addr_i) && (req_word < addr_q);
      end
      pmp_pkg::PMP_MODE_NA4: begin
        match_o = (req_word == addr_q);
      end
      pmp_pkg::PMP_MODE_NAPOT: begin
        match_o = ((req_word ^ addr_q) & napot_care) == 32'd0;
      end
      default: begin
        match_o = 1'b0;
      end
    endcase
  end

  always_comb begin
    case (req_type_i)
      pmp_pkg::PMP_ACC_READ:  allow_o = cfg_q.read;
      pmp_pkg::PMP_ACC_WRITE: allow_o = cfg_q.write;
      pmp_pkg::PMP_ACC_EXEC:  allow_o = cfg_q.exec;
      default:                allow_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: pmp_unit.f
+incdir+.
pmp_pkg.sv
pmp_csr_decode.sv
pmp_region.sv
pmp_access_arbiter.sv
pmp_unit.sv
pmp_checker.sv
tb_pmp_unit.sv

// File: pmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module pmp_unit (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        csr_we_i,
  input  wire  [11:0]                csr_addr_i,
  input  wire  [31:0]                csr_wdata_i,
  input  wire  pmp_pkg::priv_e       csr_priv_i,
  output logic [31:0]                csr_rdata_o,
  output logic                       csr_illegal_o,
  input  wire                        req_valid_i,
  input  wire  [31:0]                req_addr_i,
  input  wire  pmp_pkg::pmp_access_e req_type_i,
  input  wire  pmp_pkg::priv_e       req_priv_i,
  output logic                       resp_valid_o,
  output logic                       resp_fault_o,
  output logic [`PMP_CAUSE_W-1:0]    resp_cause_o
);

  pmp_pkg::pmpncfg_t [`PMP_REGIONS-1:0] region_cfg;
  pmp_pkg::pmpncfg_t [`PMP_REGIONS-1:0] cfg_wdata;
  pmp_pkg::pmpncfg_t [`PMP_REGIONS-1:0] above_cfg;
  logic [`PMP_REGIONS-1:0][31:0]        region_addr;
  logic [`PMP_REGIONS-1:0][31:0]        prev_addr;
  logic [`PMP_REGIONS-1:0]              cfg_we;
  logic [`PMP_REGIONS-1:0]              addr_we;
  logic [31:0]                          addr_wdata;
  logic [`PMP_REGIONS-1:0]              match;
  logic [`PMP_REGIONS-1:0]              allow;
  logic [`PMP_REGIONS-1:0]              lock;

  pmp_csr_decode u_csr_decode (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_priv_i    (csr_priv_i),
    .region_cfg_i  (region_cfg),
    .region_addr_i (region_addr),
    .cfg_we_o      (cfg_we),
    .cfg_wdata_o   (cfg_wdata),
    .addr_we_o     (addr_we),
    .addr_wdata_o  (addr_wdata),
    .csr_rdata_o   (csr_rdata_o),
    .csr_illegal_o (csr_illegal_o)
  );

  for (genvar i = 0; i < `PMP_REGIONS; i++) begin : gen_region
    // TOR base comes from below, lock-through from above
    if (i == 0) begin : gen_first
      assign prev_addr[i] = '0;
    end else begin : gen_chain_prev
      assign prev_addr[i] = region_addr[i-1];
    end
    if (i == `PMP_REGIONS - 1) begin : gen_last
      assign above_cfg[i] = '0;
    end else begin : gen_chain_above
      assign above_cfg[i] = region_cfg[i+1];
    end

    assign lock[i] = region_cfg[i].lock;

    pmp_region u_region (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .cfg_we_i     (cfg_we[i]),
      .cfg_wdata_i  (cfg_wdata[i]),
      .addr_we_i    (addr_we[i]),
      .addr_wdata_i (addr_wdata),
      .above_cfg_i  (above_cfg[i]),
      .prev_addr_i  (prev_addr[i]),
      .req_addr_i   (req_addr_i),
      .req_type_i   (req_type_i),
      .cfg_o        (region_cfg[i]),
      .addr_o       (region_addr[i]),
      .match_o      (match[i]),
      .allow_o      (allow[i])
    );
  end

  pmp_access_arbiter u_access_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_type_i   (req_type_i),
    .req_priv_i   (req_priv_i),
    .match_i      (match),
    .allow_i      (allow),
    .lock_i       (lock),
    .resp_valid_o (resp_valid_o),
    .resp_fault_o (resp_fault_o),
    .resp_cause_o (resp_cause_o)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_pmp_unit -f pmp_unit.f -o sim_pmp ||
  { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_pmp)
echo "$out"
echo "$out" | grep -q "RESULT: PASS" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: tb_pmp_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmp_cfg.svh"

module tb_pmp_unit;

  localparam int CFG_WORDS  = `PMP_REGIONS / 4;
  localparam int WAIT_LIMIT = 20;

  logic                    clk;
  logic                    rst_n;
  logic                    csr_we;
  logic [11:0]             csr_addr;
  logic [31:0]             csr_wdata;
  pmp_pkg::priv_e          csr_priv;
  logic [31:0]             csr_rdata;
  logic                    csr_illegal;
  logic                    req_valid;
  logic [31:0]             req_addr;
  pmp_pkg::pmp_access_e    req_type;
  pmp_pkg::priv_e          req_priv;
  logic                    resp_valid;
  logic                    resp_fault;
  logic [`PMP_CAUSE_W-1:0] resp_cause;
  logic [7:0]              test_id;
  logic                    test_end;
  logic                    run_end;
  logic                    timed_out;
  logic [31:0]             rng;
  int                      error_count;

  pmp_unit DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wdata_i   (csr_wdata),
    .csr_priv_i    (csr_priv),
    .csr_rdata_o   (csr_rdata),
    .csr_illegal_o (csr_illegal),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .req_type_i    (req_type),
    .req_priv_i    (req_priv),
    .resp_valid_o  (resp_valid),
    .resp_fault_o  (resp_fault),
    .resp_cause_o  (resp_cause)
  );

  pmp_checker u_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .csr_we_i      (csr_we),
    .csr_addr_i    (csr_addr),
    .csr_wdata_i   (csr_wdata),
    .csr_priv_i    (csr_priv),
    .csr_rdata_i   (csr_rdata),
    .csr_illegal_i (csr_illegal),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .req_type_i    (req_type),
    .req_priv_i    (req_priv),
    .resp_valid_i  (resp_valid),
    .resp_fault_i  (resp_fault),
    .resp_cause_i  (resp_cause),
    .test_id_i     (test_id),
    .test_end_i    (test_end),
    .run_end_i     (run_end),
    .error_count_o (error_count)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [11:0] random_csr_addr(input logic [31:0] r);
    if (r[4]) begin
      return 12'(`PMP_CSR_CFG_BASE + r % CFG_WORDS);
    end
    return 12'(`PMP_CSR_ADDR_BASE + r % `PMP_REGIONS);
  endfunction

  // Advance to just after the next rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (16) step();
    rst_n = 1'b1;
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d, input pmp_pkg::priv_e p);
    csr_we    = 1'b1;
    csr_addr  = a;
    csr_wdata = d;
    csr_priv  = p;
    step();
    csr_we = 1'b0;
  endtask

  task automatic read_all();
    for (int w = 0; w < CFG_WORDS; w++) begin
      csr_addr = 12'(`PMP_CSR_CFG_BASE + w);
      step();
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      csr_addr = 12'(`PMP_CSR_ADDR_BASE + i);
      step();
    end
    // Outside both ranges
    csr_addr = 12'h340;
    step();
  endtask

  task automatic random_request(input logic side_write);
    logic [31:0] r;
    r = next_rand();
    req_valid = 1'b1;
    req_type  = pmp_pkg::pmp_access_e'(2'(r % 3));
    req_priv  = r[2] ? pmp_pkg::PRIV_M : pmp_pkg::PRIV_U;
    req_addr  = r[3] ? next_rand() : (next_rand() & 32'h0000_00FF);
    csr_we    = side_write && (r[7:5] == 3'd0);
    csr_addr  = random_csr_addr(r >> 8);
    csr_priv  = r[9] ? pmp_pkg::PRIV_M : pmp_pkg::PRIV_U;
    if (csr_addr >= `PMP_CSR_ADDR_BASE) begin
      csr_wdata = next_rand() & 32'h3F;
    end else begin
      csr_wdata = next_rand() & 32'h7F7F_7F7F;
    end
    step();
  endtask

  task automatic random_config();
    logic [31:0] r;
    logic [31:0] d;
    for (int w = 0; w < CFG_WORDS; w++) begin
      r = next_rand();
      d = next_rand() & 32'h7F7F_7F7F;
      // An occasional lock
      if (r[3:0] == 4'd0) begin
        d = d | (32'h80 << (8 * r[5:4]));
      end
      csr_write(12'(`PMP_CSR_CFG_BASE + w), d, pmp_pkg::PRIV_M);
    end
    for (int i = 0; i < `PMP_REGIONS; i++) begin
      r = next_rand();
      d = (r[31:29] == 3'd0) ? next_rand() : (next_rand() & 32'h3F);
      csr_write(12'(`PMP_CSR_ADDR_BASE + i), d, pmp_pkg::PRIV_M);
    end
  endtask

  task automatic wait_illegal();
    int n;
    n = 0;
    while (!csr_illegal && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (!csr_illegal) begin
      $display("Timeout: no csr_illegal_o pulse after a U-mode write");
      timed_out = 1'b1;
    end
    step();
  endtask

  // Drain the last response, then mark the end of the test
  task automatic finish_test();
    int n;
    req_valid = 1'b0;
    csr_we    = 1'b0;
    n = 0;
    step();
    while (resp_valid && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (resp_valid) begin
      $display("Timeout: resp_valid_o stayed high after the last request");
      timed_out = 1'b1;
    end
    test_end = 1'b1;
    step();
    test_end = 1'b0;
    test_id  = test_id + 8'd1;
  endtask

  initial begin
    logic [31:0] r;
    rst_n     = 1'b0;
    csr_we    = 1'b0;
    csr_addr  = 12'h000;
    csr_wdata = 32'd0;
    csr_priv  = pmp_pkg::PRIV_M;
    req_valid = 1'b0;
    req_addr  = 32'd0;
    req_type  = pmp_pkg::PMP_ACC_READ;
    req_priv  = pmp_pkg::PRIV_M;
    test_id   = 8'd1;
    test_end  = 1'b0;
    run_end   = 1'b0;
    timed_out = 1'b0;
    rng       = 32'h41264969;
    apply_reset();

    // Reset state, all entries OFF
    read_all();
    for (int i = 0; i < 24; i++) begin
      random_request(1'b0);
    end
    finish_test();

    // WARL rectification, lock bits kept clear
    for (int i = 0; i < 32; i++) begin
      r = next_rand();
      csr_write(random_csr_addr(r), next_rand() & 32'h7F7F_7F7F, pmp_pkg::PRIV_M);
    end
    read_all();
    finish_test();

    // Entry 2 locked as TOR, which also freezes addr 1
    csr_write(12'(`PMP_CSR_ADDR_BASE + 1), 32'h40, pmp_pkg::PRIV_M);
    csr_write(12'(`PMP_CSR_ADDR_BASE + 2), 32'h80, pmp_pkg::PRIV_M);
    csr_write(12'(`PMP_CSR_ADDR_BASE + 3), 32'hC0, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_CFG_BASE, 32'h0F8F_0D0B, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_CFG_BASE, 32'h1F00_1F1F, pmp_pkg::PRIV_M);
    csr_write(12'(`PMP_CSR_ADDR_BASE + 2), 32'h123, pmp_pkg::PRIV_M);
    csr_write(12'(`PMP_CSR_ADDR_BASE + 1), 32'h77, pmp_pkg::PRIV_M);
    csr_write(12'(`PMP_CSR_ADDR_BASE + 3), 32'h99, pmp_pkg::PRIV_M);
    csr_write(`PMP_CSR_ADDR_BASE, 32'h11, pmp_pkg::PRIV_M);
    csr_write(12'(`PMP_CSR_CFG_BASE + 1), 32'h1F1F_1F1F, pmp_pkg::PRIV_M);
    for (int i = 0; i < 16; i++) begin
      random_request(1'b0);
    end
    read_all();
    finish_test();

    // U-mode writes to both ranges
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      csr_write(random_csr_addr(r), next_rand(), pmp_pkg::PRIV_U);
      wait_illegal();
    end
    csr_write(12'h340, next_rand(), pmp_pkg::PRIV_U);
    read_all();
    finish_test();

    // Random configurations with back-to-back requests
    apply_reset();
    for (int k = 0; k < 16; k++) begin
      random_config();
      for (int i = 0; i < 24; i++) begin
        random_request(1'b1);
      end
      req_valid = 1'b0;
      csr_we    = 1'b0;
    end
    finish_test();

    run_end = 1'b1;
    step();
    run_end = 1'b0;
    if (error_count == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
